// File: design/regs_lite_pkg.sv
// Shared constants and types for the AXI4-Lite byte register file.
// Twelve bytes are mapped as three 32-bit chunks at byte addresses 0 to 11.
// Only address bits [3:0] are decoded; upper address bits are ignored.
package regs_lite_pkg;

  // Register file geometry.
  localparam int unsigned RegNumBytes  = 12;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned NumChunks    = 3;
  localparam int unsigned AddrWidth    = 4;
  localparam int unsigned BusAddrWidth = 8;

  // Basic types.
  typedef logic [7:0]                     byte_t;
  typedef byte_t [RegNumBytes-1:0]        reg_bytes_t;
  typedef logic [RegNumBytes-1:0]         reg_mask_t;
  typedef logic [BusAddrWidth-1:0]        bus_addr_t;
  typedef logic [1:0]                     resp_t;

  // Bytes 1 and 4 to 7 reject AXI writes.
  // Chunk 1 is fully read-only, chunk 0 only partly.
  localparam reg_mask_t ReadOnlyMask = 12'h0F2;

  // Byte i resets to 8'h10 + i.
  localparam reg_bytes_t RegResetVal = 96'h1B1A1918_17161514_13121110;

  // Filler word returned by a rejected read.
  localparam logic [DataWidth-1:0] ReadErrData = 32'hBA5E1E55;

  // AXI response codes.
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;

  // One bus data word, seen whole or as four byte lanes.
  typedef union packed {
    logic [DataWidth-1:0]    word;
    byte_t [StrbWidth-1:0]   lanes;
  } bus_word_u;

  // Write path, master to slave.
  typedef struct packed {
    logic                   aw_valid;
    bus_addr_t              aw_addr;
    logic [2:0]             aw_prot;
    logic                   w_valid;
    bus_word_u              w_data;
    logic [StrbWidth-1:0]   w_strb;
    logic                   b_ready;
  } wr_req_t;

  // Write path, slave to master.
  typedef struct packed {
    logic                   aw_ready;
    logic                   w_ready;
    logic                   b_valid;
    resp_t                  b_resp;
  } wr_rsp_t;

  // Read path, master to slave.
  typedef struct packed {
    logic                   ar_valid;
    bus_addr_t              ar_addr;
    logic [2:0]             ar_prot;
    logic                   r_ready;
  } rd_req_t;

  // Read path, slave to master.
  typedef struct packed {
    logic                   ar_ready;
    logic                   r_valid;
    bus_word_u              r_data;
    resp_t                  r_resp;
  } rd_rsp_t;

  // Complete AXI4-Lite port.
  typedef struct packed {
    wr_req_t                wr;
    rd_req_t                rd;
  } axil_req_t;

  typedef struct packed {
    wr_rsp_t                wr;
    rd_rsp_t                rd;
  } axil_rsp_t;

endpackage

// File: design/regs_lite_write_ctrl.sv
// Write controller. AW and W are accepted together in one cycle.
// Accesses with aw_prot[0] low or offsets 12 to 15 get SLVERR and write nothing.
// A permitted write stalls while any byte of its chunk is loaded from logic.
// The B response sits in a one-slot register until b_ready.
`timescale 1ns/10ps

module regs_lite_write_ctrl (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  regs_lite_pkg::wr_req_t    wr_req_i,
  output regs_lite_pkg::wr_rsp_t    wr_rsp_o,
  input  regs_lite_pkg::reg_mask_t  reg_load_i,
  output regs_lite_pkg::reg_mask_t  axi_wr_en_o,
  output regs_lite_pkg::reg_bytes_t axi_wr_data_o
);
  import regs_lite_pkg::*;

  // Decoded write address.
  logic [AddrWidth-1:0] aw_offs;
  logic [AddrWidth-1:0] aw_chunk;
  logic                 aw_in_range;
  logic                 aw_prot_ok;
  logic                 aw_permit;

  // Per-chunk status.
  logic [NumChunks-1:0] chunk_loaded;
  logic [NumChunks-1:0] chunk_ro;

  // Handshake and B slot.
  logic                 aw_stall;
  logic                 aw_hs;
  logic                 b_free;
  logic                 b_valid_q;
  resp_t                b_resp_d;
  resp_t                b_resp_q;

  // Only the low address bits select a byte.
  assign aw_offs     = wr_req_i.aw_addr[AddrWidth-1:0];
  assign aw_chunk    = aw_offs / AddrWidth'(StrbWidth);
  assign aw_in_range = (aw_offs < AddrWidth'(RegNumBytes));
  // Privileged access required.
  assign aw_prot_ok  = wr_req_i.aw_prot[0];
  assign aw_permit   = aw_in_range & aw_prot_ok;

  // A chunk is busy if any of its bytes is loaded.
  // It is fully read-only if every byte rejects AXI writes.
  always_comb begin
    for (int unsigned c = 0; c < NumChunks; c++) begin
      chunk_loaded[c] = |reg_load_i[c*StrbWidth +: StrbWidth];
      chunk_ro[c]     = &ReadOnlyMask[c*StrbWidth +: StrbWidth];
    end
  end

  // Stall and response code for the addressed chunk.
  // Rejected accesses never stall and always answer SLVERR.
  always_comb begin
    aw_stall = 1'b0;
    b_resp_d = RespSlvErr;
    for (int unsigned c = 0; c < NumChunks; c++) begin
      if (aw_permit && (aw_chunk == AddrWidth'(c))) begin
        aw_stall = chunk_loaded[c];
        b_resp_d = chunk_ro[c] ? RespSlvErr : RespOkay;
      end
    end
  end

  // Slot takes a new response when empty or draining.
  assign b_free = ~b_valid_q | wr_req_i.b_ready;
  assign aw_hs  = wr_req_i.aw_valid & wr_req_i.w_valid & b_free & ~aw_stall;

  // Byte enables and data spread onto the register positions.
  always_comb begin
    for (int unsigned i = 0; i < RegNumBytes; i++) begin
      axi_wr_data_o[i] = wr_req_i.w_data.lanes[i % StrbWidth];
      axi_wr_en_o[i]   = aw_hs & aw_permit
                       & (aw_chunk == AddrWidth'(i / StrbWidth))
                       & wr_req_i.w_strb[i % StrbWidth]
                       & ~ReadOnlyMask[i];
    end
  end

  // B slot valid.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_valid_q <= 1'b0;
    end else if (aw_hs) begin
      b_valid_q <= 1'b1;
    end else if (wr_req_i.b_ready) begin
      b_valid_q <= 1'b0;
    end
  end

  // B slot payload, held stable until drained.
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      b_resp_q <= b_resp_d;
    end
  end

  assign wr_rsp_o.aw_ready = aw_hs;
  assign wr_rsp_o.w_ready  = aw_hs;
  assign wr_rsp_o.b_valid  = b_valid_q;
  assign wr_rsp_o.b_resp   = b_resp_q;

endmodule

// File: design/regs_lite_read_ctrl.sv
// Read controller. A read returns the whole addressed chunk.
// Rejected reads (ar_prot[0] low, offsets 12 to 15) return the filler word with SLVERR.
// Data is sampled at the AR handshake and held in a one-slot R register.
`timescale 1ns/10ps

module regs_lite_read_ctrl (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  regs_lite_pkg::rd_req_t    rd_req_i,
  output regs_lite_pkg::rd_rsp_t    rd_rsp_o,
  input  regs_lite_pkg::reg_bytes_t reg_q_i
);
  import regs_lite_pkg::*;

  // Decoded read address.
  logic [AddrWidth-1:0] ar_offs;
  logic [AddrWidth-1:0] ar_chunk;
  logic                 ar_permit;

  // Handshake and R slot.
  logic                 r_free;
  logic                 ar_hs;
  logic                 r_valid_q;
  bus_word_u            r_data_d;
  bus_word_u            r_data_q;
  resp_t                r_resp_d;
  resp_t                r_resp_q;

  assign ar_offs   = rd_req_i.ar_addr[AddrWidth-1:0];
  assign ar_chunk  = ar_offs / AddrWidth'(StrbWidth);
  // In range and privileged.
  assign ar_permit = (ar_offs < AddrWidth'(RegNumBytes)) & rd_req_i.ar_prot[0];

  // Chunk mux onto the byte lanes.
  // Default is the filler word with an error.
  always_comb begin
    r_data_d.word = ReadErrData;
    r_resp_d      = RespSlvErr;
    if (ar_permit) begin
      r_resp_d = RespOkay;
      for (int unsigned c = 0; c < NumChunks; c++) begin
        if (ar_chunk == AddrWidth'(c)) begin
          for (int unsigned i = 0; i < StrbWidth; i++) begin
            r_data_d.lanes[i] = reg_q_i[c*StrbWidth + i];
          end
        end
      end
    end
  end

  // Slot is free when empty or draining this cycle.
  assign r_free = ~r_valid_q | rd_req_i.r_ready;
  assign ar_hs  = rd_req_i.ar_valid & r_free;

  // R slot valid.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else if (ar_hs) begin
      r_valid_q <= 1'b1;
    end else if (rd_req_i.r_ready) begin
      r_valid_q <= 1'b0;
    end
  end

  // R payload, loaded only on a new request.
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      r_data_q <= r_data_d;
      r_resp_q <= r_resp_d;
    end
  end

  assign rd_rsp_o.ar_ready = r_free;
  assign rd_rsp_o.r_valid  = r_valid_q;
  assign rd_rsp_o.r_data   = r_data_q;
  assign rd_rsp_o.r_resp   = r_resp_q;

endmodule

// File: design/regs_lite_byte_array.sv
// Twelve byte registers with individual reset values.
// A direct load wins over an AXI write to the same byte.
// Loads also reach read-only bytes; only AXI writes are masked.
`timescale 1ns/10ps

module regs_lite_byte_array (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  regs_lite_pkg::reg_mask_t  axi_wr_en_i,
  input  regs_lite_pkg::reg_bytes_t axi_wr_data_i,
  input  regs_lite_pkg::reg_mask_t  reg_load_i,
  input  regs_lite_pkg::reg_bytes_t reg_d_i,
  output regs_lite_pkg::reg_bytes_t reg_q_o
);
  import regs_lite_pkg::*;

  reg_bytes_t reg_q;
  reg_bytes_t reg_d;
  reg_mask_t  reg_update;

  // Select the source per byte.
  always_comb begin
    for (int unsigned i = 0; i < RegNumBytes; i++) begin
      // Load data has priority.
      if (reg_load_i[i]) begin
        reg_d[i] = reg_d_i[i];
      end else begin
        reg_d[i] = axi_wr_data_i[i];
      end
    end
  end

  assign reg_update = reg_load_i | axi_wr_en_i;

  // Byte registers.
  always_ff @(posedge clk_i) begin
    for (int unsigned i = 0; i < RegNumBytes; i++) begin
      if (reset_i) begin
        reg_q[i] <= RegResetVal[i];
      end else if (reg_update[i]) begin
        reg_q[i] <= reg_d[i];
      end
    end
  end

  assign reg_q_o = reg_q;

endmodule

// File: design/regs_lite_top.sv
// AXI4-Lite register file, 12 bytes in three 32-bit chunks.
// Reads and writes have one cycle of latency through registered B and R slots.
// reg_load_i stalls AXI writes to the loaded chunk for as long as it is held.
`timescale 1ns/10ps

module regs_lite_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  regs_lite_pkg::axil_req_t  axil_req_i,
  output regs_lite_pkg::axil_rsp_t  axil_rsp_o,
  input  regs_lite_pkg::reg_bytes_t reg_d_i,
  input  regs_lite_pkg::reg_mask_t  reg_load_i,
  output regs_lite_pkg::reg_bytes_t reg_q_o
);
  import regs_lite_pkg::*;

  // Per-direction channel bundles.
  wr_req_t    wr_req;
  wr_rsp_t    wr_rsp;
  rd_req_t    rd_req;
  rd_rsp_t    rd_rsp;

  // Write controller to byte array.
  reg_mask_t  axi_wr_en;
  reg_bytes_t axi_wr_data;

  // Register state.
  reg_bytes_t reg_q;

  // Split the bus into its write and read halves.
  assign wr_req         = axil_req_i.wr;
  assign rd_req         = axil_req_i.rd;
  assign axil_rsp_o.wr  = wr_rsp;
  assign axil_rsp_o.rd  = rd_rsp;

  // AW, W and B.
  regs_lite_write_ctrl u_write_ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .wr_req_i      (wr_req),
    .wr_rsp_o      (wr_rsp),
    .reg_load_i    (reg_load_i),
    .axi_wr_en_o   (axi_wr_en),
    .axi_wr_data_o (axi_wr_data)
  );

  // AR and R.
  regs_lite_read_ctrl u_read_ctrl (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .rd_req_i (rd_req),
    .rd_rsp_o (rd_rsp),
    .reg_q_i  (reg_q)
  );

  // Register storage.
  regs_lite_byte_array u_byte_array (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .axi_wr_en_i   (axi_wr_en),
    .axi_wr_data_i (axi_wr_data),
    .reg_load_i    (reg_load_i),
    .reg_d_i       (reg_d_i),
    .reg_q_o       (reg_q)
  );

  assign reg_q_o = reg_q;

endmodule

// File: test/regs_lite_tb.sv
// Testbench for the AXI4-Lite byte register file.
// Inputs change 1 ns after the rising edge; outputs are sampled at the falling edge.
// Expected values come from a local model of the register rules.
// The run stops at the first mismatch.
`timescale 1ns/10ps

module regs_lite_tb;
  import regs_lite_pkg::*;

  localparam int          ClkPeriod   = 100;
  localparam int          ResetCycles = 16;
  localparam int          DirectedOps = 40;
  localparam int          RandomOps   = 300;
  // Each operation gets a budget of 20 cycles.
  localparam int          MaxCycles   = (ResetCycles + DirectedOps + RandomOps) * 20;
  localparam logic [31:0] Seed        = 32'h2ace22c6;
  localparam logic [31:0] ErrWord     = 32'hBA5E1E55;
  localparam resp_t       Okay        = 2'b00;
  localparam resp_t       SlvErr      = 2'b10;

  logic        clk_i;
  logic        reset_i;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  reg_bytes_t  reg_d;
  reg_mask_t   reg_load;
  reg_bytes_t  reg_q;

  // Stimulus copies of the request fields and the ready lines.
  wr_req_t     wr_drv;
  rd_req_t     rd_drv;
  logic        b_ready_drv;
  logic        r_ready_drv;
  logic        bp_on;

  // Model state and expected responses in order.
  reg_bytes_t  model;
  resp_t       exp_b_q[$];
  logic [31:0] exp_r_data_q[$];
  resp_t       exp_r_resp_q[$];

  // Last sample of a response still waiting for ready.
  logic        b_wait;
  resp_t       b_resp_last;
  logic        r_wait;
  logic [31:0] r_data_last;
  resp_t       r_resp_last;

  regs_lite_top u_dut (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp),
    .reg_d_i    (reg_d),
    .reg_load_i (reg_load),
    .reg_q_o    (reg_q)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  always_comb begin
    axil_req.wr         = wr_drv;
    axil_req.wr.b_ready = b_ready_drv;
    axil_req.rd         = rd_drv;
    axil_req.rd.r_ready = r_ready_drv;
  end

  // Bytes 1 and 4 to 7 ignore bus writes.
  function automatic logic byte_is_ro(input int idx);
    return (idx == 1) || ((idx >= 4) && (idx <= 7));
  endfunction

  // Privileged access to offsets 0 to 11 only.
  function automatic logic access_ok(input bus_addr_t addr, input logic [2:0] prot);
    return prot[0] && (addr[3:0] < 4'd12);
  endfunction

  // Expected bytes and B response after one write.
  function automatic resp_t model_write(input reg_bytes_t cur, input bus_addr_t addr,
      input logic [2:0] prot, input logic [31:0] data, input logic [3:0] strb,
      output reg_bytes_t nxt);
    int   base;
    logic all_ro;
    nxt = cur;
    if (!access_ok(addr, prot)) begin
      return SlvErr;
    end
    base   = 4 * int'(addr[3:2]);
    all_ro = 1'b1;
    for (int k = 0; k < 4; k++) begin
      if (!byte_is_ro(base + k)) begin
        all_ro = 1'b0;
        if (strb[k]) begin
          nxt[base + k] = data[8*k +: 8];
        end
      end
    end
    return all_ro ? SlvErr : Okay;
  endfunction

  // Expected R data and response of one read.
  function automatic logic [31:0] model_read(input reg_bytes_t cur, input bus_addr_t addr,
      input logic [2:0] prot, output resp_t resp);
    int          base;
    logic [31:0] word;
    if (!access_ok(addr, prot)) begin
      resp = SlvErr;
      return ErrWord;
    end
    base = 4 * int'(addr[3:2]);
    for (int k = 0; k < 4; k++) begin
      word[8*k +: 8] = cur[base + k];
    end
    resp = Okay;
    return word;
  endfunction

  task automatic abort_run(input string reason);
    if (reason.len() > 0) begin
      $display("%s", reason);
    end
    $display("TESTBENCH FAILED");
    $fatal(1, "Run stopped at %0d ns.", $time);
  endtask

  task automatic check_val(input string name, input logic [95:0] exp,
      input logic [95:0] act);
    if (act !== exp) begin
      $display("[ERROR] time %0d ns: %s expected %0h, actual %0h", $time, name, exp, act);
      abort_run("");
    end
  endtask

  // One AW/W transfer. Called and left 1 ns after a rising edge.
  task automatic write_req(input bus_addr_t addr, input logic [2:0] prot,
      input logic [31:0] data, input logic [3:0] strb);
    reg_bytes_t nxt;
    resp_t      resp;
    wr_drv.aw_valid    = 1'b1;
    wr_drv.aw_addr     = addr;
    wr_drv.aw_prot     = prot;
    wr_drv.w_valid     = 1'b1;
    wr_drv.w_data.word = data;
    wr_drv.w_strb      = strb;
    do begin
      @(negedge clk_i);
    end while (!axil_rsp.wr.aw_ready);
    check_val("w_ready", 96'(1'b1), 96'(axil_rsp.wr.w_ready));
    // Handshake at the coming edge.
    resp  = model_write(model, addr, prot, data, strb, nxt);
    model = nxt;
    exp_b_q.push_back(resp);
    @(posedge clk_i);
    #1;
    wr_drv.aw_valid = 1'b0;
    wr_drv.w_valid  = 1'b0;
  endtask

  // One AR transfer. Data is taken from the state before the handshake edge.
  task automatic read_req(input bus_addr_t addr, input logic [2:0] prot);
    logic [31:0] data;
    resp_t       resp;
    rd_drv.ar_valid = 1'b1;
    rd_drv.ar_addr  = addr;
    rd_drv.ar_prot  = prot;
    do begin
      @(negedge clk_i);
    end while (!axil_rsp.rd.ar_ready);
    data = model_read(model, addr, prot, resp);
    exp_r_data_q.push_back(data);
    exp_r_resp_q.push_back(resp);
    @(posedge clk_i);
    #1;
    rd_drv.ar_valid = 1'b0;
  endtask

  task automatic wait_responses();
    while ((exp_b_q.size() > 0) || (exp_r_resp_q.size() > 0)) begin
      @(posedge clk_i);
    end
    #1;
  endtask

  task automatic check_regs();
    @(negedge clk_i);
    check_val("reg_q_o", 96'(model), 96'(reg_q));
    @(posedge clk_i);
    #1;
  endtask

  // Every B and R handshake against the oldest expected entry.
  // A response waiting for ready must not change.
  always @(negedge clk_i) begin
    if (reset_i) begin
      b_wait = 1'b0;
      r_wait = 1'b0;
    end else begin
      if (b_wait) begin
        check_val("b_valid (held)", 96'(1'b1), 96'(axil_rsp.wr.b_valid));
        check_val("b_resp (held)", 96'(b_resp_last), 96'(axil_rsp.wr.b_resp));
      end
      if (r_wait) begin
        check_val("r_valid (held)", 96'(1'b1), 96'(axil_rsp.rd.r_valid));
        check_val("r_data (held)", 96'(r_data_last), 96'(axil_rsp.rd.r_data.word));
        check_val("r_resp (held)", 96'(r_resp_last), 96'(axil_rsp.rd.r_resp));
      end
      if (axil_rsp.wr.b_valid && axil_req.wr.b_ready) begin
        if (exp_b_q.size() == 0) begin
          abort_run("A B response came with no write outstanding.");
        end else begin
          check_val("b_resp", 96'(exp_b_q[0]), 96'(axil_rsp.wr.b_resp));
          void'(exp_b_q.pop_front());
        end
      end
      if (axil_rsp.rd.r_valid && axil_req.rd.r_ready) begin
        if (exp_r_resp_q.size() == 0) begin
          abort_run("An R response came with no read outstanding.");
        end else begin
          check_val("r_data", 96'(exp_r_data_q[0]), 96'(axil_rsp.rd.r_data.word));
          check_val("r_resp", 96'(exp_r_resp_q[0]), 96'(axil_rsp.rd.r_resp));
          void'(exp_r_data_q.pop_front());
          void'(exp_r_resp_q.pop_front());
        end
      end
      b_wait      = axil_rsp.wr.b_valid & ~axil_req.wr.b_ready;
      b_resp_last = axil_rsp.wr.b_resp;
      r_wait      = axil_rsp.rd.r_valid & ~axil_req.rd.r_ready;
      r_data_last = axil_rsp.rd.r_data.word;
      r_resp_last = axil_rsp.rd.r_resp;
    end
  end

  // Ready lines toggle at random only while back-pressure is on.
  initial begin
    b_ready_drv = 1'b1;
    r_ready_drv = 1'b1;
    forever begin
      @(posedge clk_i);
      #1;
      if (bp_on) begin
        b_ready_drv = 1'($urandom);
        r_ready_drv = 1'($urandom);
      end else begin
        b_ready_drv = 1'b1;
        r_ready_drv = 1'b1;
      end
    end
  end

  initial begin
    #(MaxCycles * ClkPeriod);
    abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles.",
                        MaxCycles));
  end

  initial begin
    bus_addr_t  addr;
    logic [2:0] prot;
    void'($urandom(Seed));
    clk_i    = 1'b0;
    reset_i  = 1'b1;
    wr_drv   = '0;
    rd_drv   = '0;
    reg_d    = '0;
    reg_load = '0;
    bp_on    = 1'b0;
    // Byte i comes out of reset as 8'h10 + i.
    for (int i = 0; i < 12; i++) begin
      model[i] = 8'h10 + 8'(i);
    end
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Reset values and idle handshake outputs.
    @(negedge clk_i);
    check_val("aw_ready", 96'(1'b0), 96'(axil_rsp.wr.aw_ready));
    check_val("ar_ready", 96'(1'b1), 96'(axil_rsp.rd.ar_ready));
    check_val("b_valid", 96'(1'b0), 96'(axil_rsp.wr.b_valid));
    check_val("r_valid", 96'(1'b0), 96'(axil_rsp.rd.r_valid));
    check_val("reg_q_o", 96'(model), 96'(reg_q));
    @(posedge clk_i);
    #1;
    for (int c = 0; c < 3; c++) begin
      read_req(8'(4 * c), 3'b001);
    end
    wait_responses();

    // Strobed writes to chunk 2 with varied upper address bits.
    for (int n = 0; n < 8; n++) begin
      write_req(8'({4'(n), 4'h8}), 3'b001, $urandom, 4'(n * 5 + 1));
      read_req(8'h08, 3'b001);
    end
    wait_responses();
    check_regs();

    // Partly and fully read-only chunks.
    write_req(8'h00, 3'b001, 32'hA1B2C3D4, 4'hF);
    write_req(8'h04, 3'b001, 32'h0F0E0D0C, 4'hF);
    read_req(8'h00, 3'b001);
    read_req(8'h04, 3'b001);
    wait_responses();
    check_regs();

    // Unprivileged and out-of-range accesses.
    write_req(8'h08, 3'b000, 32'hDEADBEEF, 4'hF);
    write_req(8'h0C, 3'b001, 32'hDEADBEEF, 4'hF);
    read_req(8'h08, 3'b110);
    read_req(8'h0C, 3'b001);
    read_req(8'h08, 3'b001);
    wait_responses();
    check_regs();

    // Load on byte 9 stalls a write to chunk 2.
    reg_d[9]    = 8'hC3;
    reg_load[9] = 1'b1;
    @(posedge clk_i);
    #1;
    model[9]           = 8'hC3;
    wr_drv.aw_valid    = 1'b1;
    wr_drv.aw_addr     = 8'h08;
    wr_drv.aw_prot     = 3'b001;
    wr_drv.w_valid     = 1'b1;
    wr_drv.w_data.word = 32'h5A6B7C8D;
    wr_drv.w_strb      = 4'b0110;
    repeat (4) begin
      @(negedge clk_i);
      check_val("aw_ready (stalled)", 96'(1'b0), 96'(axil_rsp.wr.aw_ready));
      check_val("reg_q_o", 96'(model), 96'(reg_q));
    end
    @(posedge clk_i);
    #1;
    reg_load = '0;
    // The same write goes through once the load is released.
    write_req(8'h08, 3'b001, 32'h5A6B7C8D, 4'b0110);
    check_regs();
    read_req(8'h08, 3'b001);
    wait_responses();

    // Random traffic with random B and R back-pressure.
    bp_on = 1'b1;
    for (int n = 0; n < RandomOps; n++) begin
      addr = 8'($urandom);
      prot = 3'($urandom);
      if (($urandom % 4) != 0) begin
        prot[0] = 1'b1;
      end
      if (($urandom % 2) != 0) begin
        write_req(addr, prot, $urandom, 4'($urandom));
      end else begin
        read_req(addr, prot);
      end
      if (($urandom % 4) == 0) begin
        @(posedge clk_i);
        #1;
      end
    end
    wait_responses();
    bp_on = 1'b0;
    @(posedge clk_i);
    #1;
    check_regs();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: regs_lite.f
design/regs_lite_pkg.sv
design/regs_lite_write_ctrl.sv
design/regs_lite_read_ctrl.sv
design/regs_lite_byte_array.sv
design/regs_lite_top.sv
test/regs_lite_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the register file testbench with Verilator and runs it.
# Exits with a non-zero status on a build error or a failed run.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
COMPILE_LOG=compile.log
SIM_LOG=sim.log

verilator --binary --timing -f regs_lite.f --top-module regs_lite_tb \
  -Mdir "$BUILD_DIR" -o sim_regs_lite > "$COMPILE_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $COMPILE_LOG"
  exit 1
fi

"$BUILD_DIR/sim_regs_lite" > "$SIM_LOG" 2>&1
run_status=$?

if grep -q "TESTBENCH FAILED" "$SIM_LOG"; then
  echo "Simulation reported a failure, see $SIM_LOG"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status, see $SIM_LOG"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
